// ==== logic/bpu_macros.svh ====
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// datapath
`define XLEN              32
`define HIST_LEN          16      // global history bits

// direction tables
`define BIMODAL_ENTRIES   512
`define TAGE_ENTRIES      256     // per tagged table
`define TAG_W             10
`define PARTIAL_TAG_BITS  6       // upper tag bits compared on lookup

// target buffer
`define BTB_ENTRIES       256
`define BTB_TAG_W         22      // top pc bits above the index

// rv32 opcodes of the control transfers
`define OPC_BRANCH        7'b1100011
`define OPC_JAL           7'b1101111
`define OPC_JALR          7'b1100111

`endif

// ==== logic/bpu_pkg.sv ====
`include "bpu_macros.svh"

package bpu_pkg;

    // address or raw instruction word
    typedef logic [`XLEN-1:0] addr_t;

    typedef logic [`HIST_LEN-1:0] hist_t;   // newest outcome in bit 0

    // 2-bit saturating counter, msb is the taken prediction
    typedef logic [1:0] ctr_t;

    // tagged table entry (T0 and T1)
    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        ctr_t               ctr;
    } tage_entry_t;

    // direct-mapped BTB entry
    typedef struct packed {
        logic                   valid;
        logic [`BTB_TAG_W-1:0]  tag;
        addr_t                  target;
    } btb_entry_t;

    // component that supplied the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL,
        PROV_T0,
        PROV_T1
    } provider_e;

endpackage

// ==== logic/pred_table.sv ====
`timescale 1ns/100ps

// direct-mapped register table, one lookup port and one update port
module pred_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     DEPTH     = 256,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     rst,

    // lookup
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,

    // update
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i,
    output entry_t                   wr_old_o
);

    entry_t mem [DEPTH];

    assign rd_data_o = mem[rd_idx_i];   // combinational read
    assign wr_old_o  = mem[wr_idx_i];   // current entry for read-modify-write

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;     // visible to the lookup next cycle
        end
    end

endmodule

// ==== logic/inst_decode.sv ====
`timescale 1ns/100ps
`include "bpu_macros.svh"

// classifies the fetched word and extracts the pc-relative offsets
module inst_decode (
    input  bpu_pkg::addr_t inst_i,

    output logic           is_branch_o,
    output logic           is_jal_o,
    output logic           is_jalr_o,

    output bpu_pkg::addr_t branch_off_o,
    output bpu_pkg::addr_t jal_off_o
);

    logic [6:0] opcode;

    assign opcode = inst_i[6:0];

    assign is_branch_o = (opcode == `OPC_BRANCH);
    assign is_jal_o    = (opcode == `OPC_JAL);
    assign is_jalr_o   = (opcode == `OPC_JALR);

    // B-type immediate, bit 0 always zero
    assign branch_off_o = {
        {20{inst_i[31]}},   // sign
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // J-type immediate
    assign jal_off_o = {
        {12{inst_i[31]}},   // sign
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

endmodule

// ==== logic/tage_predictor.sv ====
`timescale 1ns/100ps
`include "bpu_macros.svh"

// bimodal base plus two tagged tables, priority T1 > T0 > bimodal
module tage_predictor (
    input  logic           clk,
    input  logic           rst,

    input  bpu_pkg::addr_t pc_i,
    output logic           taken_o,

    input  logic           upd_valid_i,
    input  logic           upd_taken_i,
    input  logic           upd_correct_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  bpu_pkg::hist_t upd_hist_i,

    output bpu_pkg::hist_t history_o
);

    import bpu_pkg::*;

    localparam int BM_IDX_W = $clog2(`BIMODAL_ENTRIES);
    localparam int TG_IDX_W = $clog2(`TAGE_ENTRIES);

    // hashes shared by lookup and update
    function automatic logic [BM_IDX_W-1:0] bm_index(addr_t pc);
        return pc[9:1];
    endfunction

    function automatic logic [TG_IDX_W-1:0] t0_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic logic [`TAG_W-1:0] t0_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic logic [TG_IDX_W-1:0] t1_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic logic [`TAG_W-1:0] t1_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ {{(`TAG_W-8){1'b0}}, h[7:0]};
    endfunction

    // valid entry and matching upper tag bits
    function automatic logic tag_hit(tage_entry_t e, logic [`TAG_W-1:0] tag);
        return e.valid &&
               (e.tag[`TAG_W-1 -: `PARTIAL_TAG_BITS] == tag[`TAG_W-1 -: `PARTIAL_TAG_BITS]);
    endfunction

    function automatic provider_e pick(tage_entry_t t1, logic [`TAG_W-1:0] t1_t,
                                       tage_entry_t t0, logic [`TAG_W-1:0] t0_t);
        if (tag_hit(t1, t1_t)) return PROV_T1;
        if (tag_hit(t0, t0_t)) return PROV_T0;
        return PROV_BIMODAL;
    endfunction

    function automatic ctr_t ctr_step(ctr_t c, logic taken);
        if (taken) return (c == 2'b11) ? c : c + 2'b01;
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    hist_t       ghist;
    ctr_t        l_bm;
    tage_entry_t l_t0;
    tage_entry_t l_t1;
    provider_e   l_prov;

    ctr_t        u_bm_old;
    tage_entry_t u_t0_old;
    tage_entry_t u_t1_old;
    provider_e   u_prov;
    logic        t0_we;
    logic        t1_we;
    tage_entry_t t0_wd;
    tage_entry_t t1_wd;

    pred_table #(.entry_t(ctr_t), .DEPTH(`BIMODAL_ENTRIES), .RESET_VAL(2'b01)) u_bimodal (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (bm_index(pc_i)),
        .rd_data_o (l_bm),
        .wr_en_i   (upd_valid_i),                   // base always trains
        .wr_idx_i  (bm_index(upd_pc_i)),
        .wr_data_i (ctr_step(u_bm_old, upd_taken_i)),
        .wr_old_o  (u_bm_old)
    );

    pred_table #(.entry_t(tage_entry_t), .DEPTH(`TAGE_ENTRIES), .RESET_VAL('0)) u_t0 (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (t0_index(pc_i, ghist)),
        .rd_data_o (l_t0),
        .wr_en_i   (t0_we),
        .wr_idx_i  (t0_index(upd_pc_i, upd_hist_i)),
        .wr_data_i (t0_wd),
        .wr_old_o  (u_t0_old)
    );

    pred_table #(.entry_t(tage_entry_t), .DEPTH(`TAGE_ENTRIES), .RESET_VAL('0)) u_t1 (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (t1_index(pc_i, ghist)),
        .rd_data_o (l_t1),
        .wr_en_i   (t1_we),
        .wr_idx_i  (t1_index(upd_pc_i, upd_hist_i)),
        .wr_data_i (t1_wd),
        .wr_old_o  (u_t1_old)
    );

    // lookup
    assign l_prov = pick(l_t1, t1_tag(pc_i, ghist), l_t0, t0_tag(pc_i, ghist));

    always_comb begin
        case (l_prov)
            PROV_T1: taken_o = l_t1.ctr[1];
            PROV_T0: taken_o = l_t0.ctr[1];
            default: taken_o = l_bm[1];
        endcase
    end

    // update, provider recomputed from the update-side entries
    assign u_prov = pick(u_t1_old, t1_tag(upd_pc_i, upd_hist_i),
                         u_t0_old, t0_tag(upd_pc_i, upd_hist_i));

    always_comb begin
        t0_we = 1'b0;
        t1_we = 1'b0;
        t0_wd = u_t0_old;
        t1_wd = u_t1_old;
        if (upd_valid_i && !upd_correct_i) begin
            case (u_prov)
                PROV_T1: begin
                    t1_we     = 1'b1;
                    t1_wd.ctr = upd_taken_i ? 2'b11 : 2'b00;   // jump to strong
                end
                PROV_T0: begin
                    t0_we     = 1'b1;
                    t0_wd.ctr = upd_taken_i ? 2'b11 : 2'b00;
                end
                default: begin
                    // allocate the longer history first
                    if (!u_t1_old.valid || u_t1_old.tag != t1_tag(upd_pc_i, upd_hist_i)) begin
                        t1_we = 1'b1;
                        t1_wd = '{valid: 1'b1, tag: t1_tag(upd_pc_i, upd_hist_i),
                                  ctr: upd_taken_i ? 2'b10 : 2'b01};
                    end else if (!u_t0_old.valid ||
                                 u_t0_old.tag != t0_tag(upd_pc_i, upd_hist_i)) begin
                        t0_we = 1'b1;
                        t0_wd = '{valid: 1'b1, tag: t0_tag(upd_pc_i, upd_hist_i),
                                  ctr: upd_taken_i ? 2'b10 : 2'b01};
                    end
                end
            endcase
        end else if (upd_valid_i) begin
            if (u_prov == PROV_T1) begin
                t1_we     = 1'b1;
                t1_wd.ctr = ctr_step(u_t1_old.ctr, upd_taken_i);
            end else if (u_prov == PROV_T0) begin
                t0_we     = 1'b1;
                t0_wd.ctr = ctr_step(u_t0_old.ctr, upd_taken_i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (upd_valid_i) begin
            ghist <= {ghist[`HIST_LEN-2:0], upd_taken_i};   // newest at bit 0
        end
    end

    assign history_o = ghist;

endmodule

// ==== logic/btb.sv ====
`timescale 1ns/100ps
`include "bpu_macros.svh"

// direct-mapped branch target buffer
module btb (
    input  logic           clk,
    input  logic           rst,

    input  bpu_pkg::addr_t pc_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o,

    input  logic           upd_valid_i,
    input  logic           upd_taken_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  bpu_pkg::addr_t upd_target_i
);

    import bpu_pkg::*;

    localparam int IDX_W = $clog2(`BTB_ENTRIES);

    logic [IDX_W-1:0]      rd_idx;
    logic [IDX_W-1:0]      wr_idx;
    logic [`BTB_TAG_W-1:0] rd_tag;
    btb_entry_t            rd_entry;
    btb_entry_t            wr_entry;

    assign rd_idx = pc_i[IDX_W+1:2];                  // word aligned index
    assign rd_tag = pc_i[`XLEN-1 -: `BTB_TAG_W];
    assign wr_idx = upd_pc_i[IDX_W+1:2];

    // only taken transfers are recorded
    assign wr_entry = '{valid:  1'b1,
                        tag:    upd_pc_i[`XLEN-1 -: `BTB_TAG_W],
                        target: upd_target_i};

    pred_table #(.entry_t(btb_entry_t), .DEPTH(`BTB_ENTRIES), .RESET_VAL('0)) u_table (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_entry),
        .wr_en_i   (upd_valid_i && upd_taken_i),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_entry),
        .wr_old_o  ()
    );

    assign hit_o    = rd_entry.valid && (rd_entry.tag == rd_tag);   // full tag compare
    assign target_o = rd_entry.target;

endmodule

// ==== logic/bpu.sv ====
`timescale 1ns/100ps

// fetch-stage branch predictor, zero-latency prediction
module bpu (
    input  logic           clk,
    input  logic           rst,

    // fetch
    input  bpu_pkg::addr_t if_pc_i,
    input  bpu_pkg::addr_t if_inst_i,

    // execute feedback
    input  logic           ex_branch_valid_i,
    input  logic           ex_branch_taken_i,
    input  logic           ex_pdt_true_i,
    input  bpu_pkg::addr_t ex_pc_i,
    input  bpu_pkg::addr_t ex_target_i,
    input  bpu_pkg::hist_t ex_history_i,

    // prediction
    output logic           branch_o,
    output logic           pdt_res_o,
    output bpu_pkg::addr_t pdt_pc_o,
    output bpu_pkg::hist_t history_o
);

    import bpu_pkg::*;

    logic  is_branch;
    logic  is_jal;
    logic  is_jalr;
    addr_t branch_off;
    addr_t jal_off;
    logic  tage_taken;
    logic  btb_hit;
    addr_t btb_target;
    addr_t seq_pc;
    addr_t rel_pc;

    inst_decode u_decode (
        .inst_i       (if_inst_i),
        .is_branch_o  (is_branch),
        .is_jal_o     (is_jal),
        .is_jalr_o    (is_jalr),
        .branch_off_o (branch_off),
        .jal_off_o    (jal_off)
    );

    tage_predictor u_tage (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (if_pc_i),
        .taken_o       (tage_taken),
        .upd_valid_i   (ex_branch_valid_i),
        .upd_taken_i   (ex_branch_taken_i),
        .upd_correct_i (ex_pdt_true_i),
        .upd_pc_i      (ex_pc_i),
        .upd_hist_i    (ex_history_i),
        .history_o     (history_o)
    );

    btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (if_pc_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_valid_i  (ex_branch_valid_i),
        .upd_taken_i  (ex_branch_taken_i),
        .upd_pc_i     (ex_pc_i),
        .upd_target_i (ex_target_i)
    );

    assign seq_pc = if_pc_i + addr_t'(4);
    assign rel_pc = if_pc_i + (is_jal ? jal_off : branch_off);  // fallback on btb miss

    assign branch_o = is_branch || is_jal || is_jalr;

    always_comb begin
        if (is_jal) begin
            pdt_res_o = 1'b1;
        end else if (is_jalr) begin
            pdt_res_o = btb_hit;        // register target only known via btb
        end else if (is_branch) begin
            pdt_res_o = tage_taken;
        end else begin
            pdt_res_o = 1'b0;
        end
    end

    always_comb begin
        if (!pdt_res_o) begin
            pdt_pc_o = seq_pc;
        end else if (btb_hit) begin
            pdt_pc_o = btb_target;
        end else begin
            pdt_pc_o = rel_pc;
        end
    end

endmodule

// ==== sim/bpu_tb.sv ====
`timescale 1ns/100ps
`include "bpu_macros.svh"

module bpu_tb;

    import bpu_pkg::*;

    localparam int ACT_LOOKUP    = 0;
    localparam int ACT_UPDATE    = 1;
    localparam int ACT_HIST      = 2;
    localparam int ACT_RESET     = 3;
    localparam int SETTLE_STEPS  = 4;     // quarter-ns polls before the next edge
    localparam int RESET_TIMEOUT = 10;
    localparam int JAL_BACK      = -2048;
    localparam int JAL_FWD       = 'h12344;
    localparam int BR_OFF        = -16;
    localparam logic [9:0] BURST = 10'b1101001011;    // oldest bit first

    localparam addr_t NOP_WORD  = 32'h0000_0013;        // addi x0, x0, 0
    localparam addr_t JALR_WORD = {12'd0, 5'd1, 3'b000, 5'd1, `OPC_JALR};

    typedef struct packed {
        logic [1:0] act;
        addr_t      pc;
        addr_t      inst;
        logic       taken;
        logic       correct;
        addr_t      target;
        logic       exp_br;
        logic       exp_res;
        addr_t      exp_pc;
        hist_t      exp_hist;
    } row_t;

    logic  clk;
    logic  rst;
    addr_t if_pc;
    addr_t if_inst;
    logic  ex_valid;
    logic  ex_taken;
    logic  ex_true;
    addr_t ex_pc;
    addr_t ex_target;
    hist_t ex_hist;
    logic  branch;
    logic  pdt_res;
    addr_t pdt_pc;
    hist_t history;

    row_t  rows[$];
    string names[$];
    hist_t model_hist;      // expected history while the table is built
    hist_t last_hist;       // history seen at the latest lookup
    int    n_tests;
    int    n_fail;
    logic  timed_out;

    bpu bpu_inst (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_branch_taken_i (ex_taken),
        .ex_pdt_true_i     (ex_true),
        .ex_pc_i           (ex_pc),
        .ex_target_i       (ex_target),
        .ex_history_i      (ex_hist),
        .branch_o          (branch),
        .pdt_res_o         (pdt_res),
        .pdt_pc_o          (pdt_pc),
        .history_o         (history)
    );

    always #2 clk = ~clk;

    // J-type encoding with rd = x1
    function automatic addr_t jal_word(int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, `OPC_JAL};
    endfunction

    // bne x1, x2
    function automatic addr_t branch_word(int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], `OPC_BRANCH};
    endfunction

    function automatic void add_lookup(string name, addr_t pc, addr_t inst,
                                       logic br, logic res, addr_t npc);
        row_t r;
        r         = '0;
        r.act     = ACT_LOOKUP;
        r.pc      = pc;
        r.inst    = inst;
        r.exp_br  = br;
        r.exp_res = res;
        r.exp_pc  = npc;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    function automatic void add_update(string name, addr_t pc, logic taken,
                                       logic correct, addr_t target);
        row_t r;
        r         = '0;
        r.act     = ACT_UPDATE;
        r.pc      = pc;
        r.taken   = taken;
        r.correct = correct;
        r.target  = target;
        model_hist = {model_hist[`HIST_LEN-2:0], taken};   // newest at bit 0
        rows.push_back(r);
        names.push_back(name);
    endfunction

    function automatic void add_hist(string name);
        row_t r;
        r          = '0;
        r.act      = ACT_HIST;
        r.exp_hist = model_hist;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    function automatic void add_reset(string name);
        row_t r;
        r          = '0;
        r.act      = ACT_RESET;
        model_hist = '0;
        rows.push_back(r);
        names.push_back(name);
    endfunction

    task automatic do_reset();
        int cycles;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst    = 1'b0;
        cycles = 0;
        while (history !== '0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (history !== '0) begin
            $display("timeout: history register still not clear after reset");
            timed_out = 1'b1;
        end
    endtask

    task automatic settle(string name);
        int steps;
        steps = 0;
        while ($isunknown({branch, pdt_res, pdt_pc}) && steps < SETTLE_STEPS) begin
            #0.25;
            steps++;
        end
        if ($isunknown({branch, pdt_res, pdt_pc})) begin
            $display("timeout: prediction outputs of %s never settled", name);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_lookup(string name, row_t r);
        n_tests++;
        if (branch !== r.exp_br || pdt_res !== r.exp_res || pdt_pc !== r.exp_pc) begin
            $display("ERR %s expected br=%0b taken=%0b pc=%h actual br=%0b taken=%0b pc=%h",
                     name, r.exp_br, r.exp_res, r.exp_pc, branch, pdt_res, pdt_pc);
            n_fail++;
        end else begin
            $display("ok  %s", name);
        end
    endtask

    task automatic check_hist(string name, hist_t exp);
        n_tests++;
        if (history !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, history);
            n_fail++;
        end else begin
            $display("ok  %s", name);
        end
    endtask

    initial begin
        addr_t pc_a;
        addr_t pc_b;
        addr_t alias_pc;
        addr_t far_pc;
        addr_t tgt_a;
        addr_t tgt_p;
        row_t  r;

        clk        = 1'b0;
        rst        = 1'b1;
        if_pc      = '0;
        if_inst    = NOP_WORD;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_true    = 1'b0;
        ex_pc      = '0;
        ex_target  = '0;
        ex_hist    = '0;
        model_hist = '0;
        last_hist  = '0;
        n_tests    = 0;
        n_fail     = 0;
        timed_out  = 1'b0;

        void'($urandom(32'hc74c));
        pc_a     = $urandom & 32'hffff_fffc;
        pc_b     = ($urandom & 32'hffff_fc00) | {22'd0, pc_a[9:2] + 8'd1, 2'b00};
        alias_pc = pc_a ^ 32'h0000_0400;       // same btb index but another tag
        far_pc   = pc_a ^ 32'h0010_0000;       // above the tage hash bits, inside the btb tag
        tgt_a    = $urandom & 32'hffff_fffc;
        tgt_p    = $urandom & 32'hffff_fffc;

        // cold predictions
        add_lookup("nonctrl_cold", pc_a, NOP_WORD, 1'b0, 1'b0, pc_a + 32'd4);
        add_lookup("branch_cold", pc_a, branch_word(BR_OFF), 1'b1, 1'b0, pc_a + 32'd4);
        add_lookup("jal_cold", pc_a, jal_word(JAL_BACK), 1'b1, 1'b1, pc_a + addr_t'(JAL_BACK));
        add_lookup("jalr_cold", pc_a, JALR_WORD, 1'b1, 1'b0, pc_a + 32'd4);

        // btb fill and alias
        add_update("jal_resolve", pc_a, 1'b1, 1'b1, tgt_a);
        add_lookup("jal_btb_hit", pc_a, jal_word(JAL_BACK), 1'b1, 1'b1, tgt_a);
        add_lookup("jalr_btb_hit", pc_a, JALR_WORD, 1'b1, 1'b1, tgt_a);
        add_lookup("jalr_alias_miss", alias_pc, JALR_WORD, 1'b1, 1'b0, alias_pc + 32'd4);
        add_lookup("jal_alias_miss", alias_pc, jal_word(JAL_FWD), 1'b1, 1'b1,
                   alias_pc + addr_t'(JAL_FWD));
        add_lookup("nonctrl_btb_hit", pc_a, NOP_WORD, 1'b0, 1'b0, pc_a + 32'd4);

        // T1 allocation under an all-taken history once bimodal is strong not-taken
        add_reset("reset_t1");
        add_lookup("branch_p_cold", pc_a, branch_word(BR_OFF), 1'b1, 1'b0, pc_a + 32'd4);
        add_update("p_not_taken_0", pc_a, 1'b0, 1'b1, pc_a + 32'd4);
        add_update("p_not_taken_1", pc_a, 1'b0, 1'b1, pc_a + 32'd4);
        for (int i = 0; i < `HIST_LEN; i++) begin
            add_update("fill_taken", pc_b, 1'b1, 1'b1, tgt_a);
        end
        add_hist("hist_all_taken");
        add_lookup("branch_p_bimodal", pc_a, branch_word(BR_OFF), 1'b1, 1'b0, pc_a + 32'd4);
        add_update("p_mispredict", pc_a, 1'b1, 1'b0, tgt_p);
        add_hist("hist_same_after_miss");
        add_lookup("branch_p_t1", pc_a, branch_word(BR_OFF), 1'b1, 1'b1, tgt_p);
        add_lookup("branch_far_alias", far_pc, branch_word(BR_OFF), 1'b1, 1'b1,
                   far_pc + addr_t'(BR_OFF));

        // history shift with a back-to-back burst
        add_reset("reset_hist");
        add_lookup("nonctrl_hist", pc_b, NOP_WORD, 1'b0, 1'b0, pc_b + 32'd4);
        for (int i = 9; i >= 0; i--) begin
            add_update("burst", pc_b, BURST[i], 1'b1, tgt_a);
        end
        add_hist("hist_burst");
        add_lookup("nonctrl_gap", pc_b, NOP_WORD, 1'b0, 1'b0, pc_b + 32'd4);
        add_update("tail_0", pc_b, 1'b0, 1'b1, tgt_a);
        add_update("tail_1", pc_b, 1'b1, 1'b1, tgt_a);
        add_hist("hist_tail");

        do_reset();

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            @(posedge clk);
            #1;                 // drive after the edge
            r        = rows[i];
            ex_valid = 1'b0;
            case (r.act)
                ACT_LOOKUP: begin
                    if_pc   = r.pc;
                    if_inst = r.inst;
                    #1;
                    settle(names[i]);
                    if (!timed_out) begin
                        check_lookup(names[i], r);
                    end
                    last_hist = history;
                end
                ACT_UPDATE: begin
                    ex_valid  = 1'b1;   // one-cycle strobe
                    ex_taken  = r.taken;
                    ex_true   = r.correct;
                    ex_pc     = r.pc;
                    ex_target = r.target;
                    ex_hist   = last_hist;
                end
                ACT_HIST: begin
                    #1;
                    check_hist(names[i], r.exp_hist);
                end
                default: begin
                    do_reset();
                end
            endcase
        end
        @(posedge clk);
        #1;
        ex_valid = 1'b0;

        $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
        if (n_fail == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/bpu_pkg.sv
logic/pred_table.sv
logic/inst_decode.sv
logic/tage_predictor.sv
logic/btb.sv
logic/bpu.sv
sim/bpu_tb.sv

// ==== Bender.yml ====
package:
  name: bpu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/bpu_pkg.sv
      - logic/pred_table.sv
      - logic/inst_decode.sv
      - logic/tage_predictor.sv
      - logic/btb.sv
      - logic/bpu.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/bpu_tb.sv
